/* verilog/dsp_isa_pkg.sv */
package dsp_isa_pkg;

    // Bit positions inside the 16-bit instruction word
    localparam int T_MSB    = 15;  // Top of the T field
    localparam int SREG_LSB = 9;   // Short immediate register code
    localparam int GRP_LSB  = 7;   // Destination group of a long immediate
    localparam int R_LSB    = 4;   // R field
    localparam int Y_LSB    = 2;   // Y field
    localparam int MODE_LSB = 0;   // Post-modify mode
    localparam int SIMM_W   = 9;   // Short immediate value width

    // T-field codes, stored as the fixed prefix of the field.
    // A trailing x in the ISA table means the low bit belongs to the operand.
    localparam logic [3:0] T_GOTO_JA = 4'b0000;   // 0000x
    localparam logic [3:0] T_CALL_JA = 4'b1000;   // 1000x
    localparam logic [4:0] T_GOTO_B  = 5'b11000;
    localparam logic [3:0] T_SHORT   = 4'b0001;   // 0001x
    localparam logic [4:0] T_LONG    = 5'b01010;
    localparam logic [4:0] T_STORE   = 5'b01100;
    localparam logic [5:0] T_LOAD    = 6'b011110; // Reaches into bit 10

    // Group code of the pointer registers in a long immediate
    localparam logic [2:0] GRP_YAAU = 3'b000;

    // Register codes
    localparam logic [2:0] REG_R0 = 3'd0;
    localparam logic [2:0] REG_R1 = 3'd1;
    localparam logic [2:0] REG_R2 = 3'd2;
    localparam logic [2:0] REG_R3 = 3'd3;
    localparam logic [2:0] REG_J  = 3'd4;

    // Short immediates flip the top bit of the register code
    localparam logic [2:0] SREG_FLIP = 3'b100;

    // Post-modify modes
    localparam logic [1:0] MODE_NONE = 2'd0;  // *rY
    localparam logic [1:0] MODE_INC  = 2'd1;  // *rY++
    localparam logic [1:0] MODE_DEC  = 2'd2;  // *rY--
    localparam logic [1:0] MODE_INCJ = 2'd3;  // *rY++j

    localparam int NUM_PTR = 4;

endpackage

/* verilog/dsp_bus_pkg.sv */
package dsp_bus_pkg;

    // Instruction and data words share one width
    typedef logic [15:0] word_t;

    // Program side
    localparam int PC_W = 12;
    typedef logic [PC_W-1:0] pc_t;

    // Data side. Pointers are kept at RAM_AW bits, never wider than this
    localparam int DATA_AW_MAX = 16;

endpackage

/* verilog/dsp_ctrl.sv */
`timescale 1ns/1ps

module dsp_ctrl
    import dsp_bus_pkg::*;
    import dsp_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  word_t      rom_dout,
    // Program counter control
    output logic       goto_ja,
    output logic       call_ja,
    output logic       goto_b,
    output logic       pc_halt,
    // Pointer and memory control
    output logic       short_load,
    output logic       long_load,
    output logic       ram_load,
    output logic       post_load,
    output logic       ram_we_req,
    // Instruction fields
    output pc_t        i_field,
    output logic [2:0] r_field,
    output logic [1:0] y_field,
    output logic [1:0] mode,
    output logic [8:0] short_imm
);

    logic       two_word;     // Current word is the trailing slot
    logic [2:0] grp;
    logic [2:0] short_reg;
    logic [2:0] long_reg;
    logic       is_short;
    logic       short_ok;
    logic       long_ok;

    assign grp       = rom_dout[GRP_LSB +: 3];
    assign short_reg = rom_dout[SREG_LSB +: 3] ^ SREG_FLIP;
    assign long_reg  = rom_dout[R_LSB +: 3];
    assign is_short  = rom_dout[T_MSB -: 4] == T_SHORT;

    // k, rb and re are not implemented
    assign short_ok = short_reg inside {REG_R0, REG_R1, REG_R2, REG_R3, REG_J};
    assign long_ok  = grp == GRP_YAAU && long_reg inside {REG_R0, REG_R1, REG_R2, REG_R3};

    // Strobes last one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            goto_ja    <= 1'b0;
            call_ja    <= 1'b0;
            goto_b     <= 1'b0;
            pc_halt    <= 1'b0;
            short_load <= 1'b0;
            long_load  <= 1'b0;
            ram_load   <= 1'b0;
            post_load  <= 1'b0;
            ram_we_req <= 1'b0;
            two_word   <= 1'b0;
        end else if (cen) begin
            goto_ja    <= 1'b0;
            call_ja    <= 1'b0;
            goto_b     <= 1'b0;
            pc_halt    <= 1'b0;
            short_load <= 1'b0;
            long_load  <= 1'b0;
            ram_load   <= 1'b0;
            post_load  <= 1'b0;
            ram_we_req <= 1'b0;
            two_word   <= 1'b0;

            if (!two_word) begin
                if (rom_dout[T_MSB -: 4] == T_GOTO_JA) begin
                    goto_ja  <= 1'b1;
                    two_word <= 1'b1;
                end else if (rom_dout[T_MSB -: 4] == T_CALL_JA) begin
                    call_ja  <= 1'b1;
                    two_word <= 1'b1;
                end else if (rom_dout[T_MSB -: 5] == T_GOTO_B) begin
                    goto_b   <= 1'b1;  // Return through pr
                    two_word <= 1'b1;
                end else if (is_short) begin
                    short_load <= short_ok;
                end else if (rom_dout[T_MSB -: 5] == T_LONG) begin
                    // Value word follows and must not run
                    long_load <= long_ok;
                    two_word  <= 1'b1;
                end else if (rom_dout[T_MSB -: 5] == T_STORE) begin
                    ram_we_req <= 1'b1;
                    post_load  <= 1'b1;
                    pc_halt    <= 1'b1;
                    two_word   <= 1'b1;
                end else if (rom_dout[T_MSB -: 6] == T_LOAD) begin
                    ram_load  <= 1'b1;
                    post_load <= 1'b1;
                    pc_halt   <= 1'b1;
                    two_word  <= 1'b1;
                end
                // Anything else runs as a no-op
            end
        end
    end

    // Operand fields, only meaningful next to a strobe
    always_ff @(posedge clk) begin
        if (cen) begin
            i_field   <= rom_dout[PC_W-1:0];
            r_field   <= is_short ? short_reg : long_reg;
            y_field   <= rom_dout[Y_LSB +: 2];
            mode      <= rom_dout[MODE_LSB +: 2];
            short_imm <= rom_dout[SIMM_W-1:0];
        end
    end

endmodule

/* verilog/dsp_pc_unit.sv */
`timescale 1ns/1ps

module dsp_pc_unit
    import dsp_bus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic goto_ja,
    input  logic call_ja,
    input  logic goto_b,
    input  logic pc_halt,
    input  pc_t  i_field,
    output pc_t  rom_addr
);

    pc_t pc;
    pc_t pr;   // Return register

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
            pr <= '0;
        end else if (cen) begin
            if (goto_ja || call_ja) begin
                pc <= i_field;
            end else if (goto_b) begin
                pc <= pr;
            end else if (!pc_halt) begin
                pc <= pc + pc_t'(1);
            end

            // pc already points past the call word here
            if (call_ja) begin
                pr <= pc;
            end
        end
    end

    assign rom_addr = pc;

endmodule

/* verilog/dsp_ptr_unit.sv */
`timescale 1ns/1ps

module dsp_ptr_unit
    import dsp_bus_pkg::*;
    import dsp_isa_pkg::*;
#(
    parameter int RAM_AW = 10,
    parameter int INDEX  = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              short_load,
    input  logic              long_load,
    input  logic              ram_load,
    input  logic              post_load,
    input  logic [2:0]        r_field,
    input  logic [1:0]        y_field,
    input  logic [1:0]        mode,
    input  logic [8:0]        short_imm,
    input  word_t             long_imm,
    input  word_t             ram_rdata,
    input  logic [RAM_AW-1:0] j,
    output logic [RAM_AW-1:0] ptr
);

    logic                   r_hit;
    logic                   y_hit;
    logic [DATA_AW_MAX-1:0] load_val;
    logic [RAM_AW-1:0]      step;

    assign r_hit = r_field == 3'(INDEX);
    assign y_hit = y_field == 2'(INDEX);

    always_comb begin
        load_val = ram_rdata;
        if (short_load) begin
            load_val = DATA_AW_MAX'(short_imm);  // Zero-extended
        end else if (long_load) begin
            load_val = long_imm;
        end
    end

    // Wraps modulo the RAM size
    always_comb begin
        case (mode)
            MODE_NONE: step = '0;
            MODE_INC:  step = RAM_AW'(1);
            MODE_DEC:  step = '1;  // Minus one
            MODE_INCJ: step = j;
            default:   step = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (cen) begin
            if (r_hit && (short_load || long_load || ram_load)) begin
                ptr <= load_val[RAM_AW-1:0];  // Load beats post-modify
            end else if (y_hit && post_load) begin
                ptr <= ptr + step;
            end
        end
    end

endmodule

/* verilog/dsp_mem_port.sv */
`timescale 1ns/1ps

module dsp_mem_port
    import dsp_bus_pkg::*;
    import dsp_isa_pkg::*;
#(
    parameter int RAM_AW = 10
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           short_load,
    input  logic                           ram_we_req,
    input  logic [2:0]                     r_field,
    input  logic [1:0]                     y_field,
    input  logic [8:0]                     short_imm,
    input  logic [NUM_PTR-1:0][RAM_AW-1:0] ptr_bus,
    output logic [RAM_AW-1:0]              ram_addr,
    output logic                           ram_we,
    output word_t                          ram_wdata,
    output logic [RAM_AW-1:0]              j
);

    // Step register for *rY++j
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            j <= '0;
        end else if (cen && short_load && r_field == REG_J) begin
            j <= RAM_AW'(short_imm);
        end
    end

    assign ram_addr  = ptr_bus[y_field];
    assign ram_wdata = word_t'(ptr_bus[r_field[1:0]]);  // Only r0-r3 can be stored
    assign ram_we    = ram_we_req;  // Held through cen low, RAM gates on cen

endmodule

/* verilog/dsp_core_top.sv */
`timescale 1ns/1ps

module dsp_core_top
    import dsp_bus_pkg::*;
    import dsp_isa_pkg::*;
#(
    parameter int RAM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    // Program ROM
    output pc_t               rom_addr,
    input  word_t             rom_dout,
    // Data RAM
    output logic [RAM_AW-1:0] ram_addr,
    output logic              ram_we,
    output word_t             ram_wdata,
    input  word_t             ram_rdata
);

    logic                           goto_ja;
    logic                           call_ja;
    logic                           goto_b;
    logic                           pc_halt;
    logic                           short_load;
    logic                           long_load;
    logic                           ram_load;
    logic                           post_load;
    logic                           ram_we_req;
    pc_t                            i_field;
    logic [2:0]                     r_field;
    logic [1:0]                     y_field;
    logic [1:0]                     mode;
    logic [8:0]                     short_imm;
    logic [RAM_AW-1:0]              j;
    logic [NUM_PTR-1:0][RAM_AW-1:0] ptr_bus;

    dsp_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .rom_dout   (rom_dout),
        .goto_ja    (goto_ja),
        .call_ja    (call_ja),
        .goto_b     (goto_b),
        .pc_halt    (pc_halt),
        .short_load (short_load),
        .long_load  (long_load),
        .ram_load   (ram_load),
        .post_load  (post_load),
        .ram_we_req (ram_we_req),
        .i_field    (i_field),
        .r_field    (r_field),
        .y_field    (y_field),
        .mode       (mode),
        .short_imm  (short_imm)
    );

    dsp_pc_unit u_pc (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .goto_ja  (goto_ja),
        .call_ja  (call_ja),
        .goto_b   (goto_b),
        .pc_halt  (pc_halt),
        .i_field  (i_field),
        .rom_addr (rom_addr)
    );

    // r0-r3
    for (genvar i = 0; i < NUM_PTR; i++) begin : g_ptr
        dsp_ptr_unit #(
            .RAM_AW (RAM_AW),
            .INDEX  (i)
        ) u_ptr (
            .clk        (clk),
            .rst        (rst),
            .cen        (cen),
            .short_load (short_load),
            .long_load  (long_load),
            .ram_load   (ram_load),
            .post_load  (post_load),
            .r_field    (r_field),
            .y_field    (y_field),
            .mode       (mode),
            .short_imm  (short_imm),
            .long_imm   (rom_dout),  // Value word sits on the ROM bus
            .ram_rdata  (ram_rdata),
            .j          (j),
            .ptr        (ptr_bus[i])
        );
    end

    dsp_mem_port #(
        .RAM_AW (RAM_AW)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .short_load (short_load),
        .ram_we_req (ram_we_req),
        .r_field    (r_field),
        .y_field    (y_field),
        .short_imm  (short_imm),
        .ptr_bus    (ptr_bus),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .j          (j)
    );

endmodule

/* verification/dsp_core_checker.sv */
`timescale 1ns/1ps

module dsp_core_checker
    import dsp_bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic cen,
    input pc_t  rom_addr,
    input logic ram_we
);

    logic we_last;  // ram_we seen at the previous enabled edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we_last <= 1'b0;
        end else if (cen) begin
            we_last <= ram_we;
        end
    end

    no_write_in_reset: assert property (@(posedge clk) rst |-> !ram_we)
        else $error("ram_we high while rst is asserted");

    // A store drives exactly one enabled edge
    single_write_edge: assert property (@(posedge clk) disable iff (rst)
        (cen && we_last) |-> !ram_we)
        else $error("ram_we held over two enabled edges");

    pc_holds_without_cen: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(rom_addr))
        else $error("rom_addr moved on an edge with cen low");

endmodule

bind dsp_core_top dsp_core_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .rom_addr (rom_addr),
    .ram_we   (ram_we)
);

/* verification/dsp_core_tb.sv */
`timescale 1ns/1ps

module dsp_core_tb
    import dsp_bus_pkg::*;
;

    localparam int NT       = 7;
    localparam int MAX_PROG = 16;
    localparam int MAX_WR   = 8;
    localparam int TIMEOUT  = 200;

    logic        clk;
    logic        rst;
    logic        cen;
    pc_t         rom_addr;
    word_t       rom_dout;
    logic [9:0]  ram_addr;
    logic        ram_we;
    word_t       ram_wdata;
    word_t       ram_rdata;

    // ROM and RAM models
    word_t rom [0:4095];
    word_t ram [0:1023];

    // Stimulus table
    string       name      [NT];
    word_t       prog      [NT][MAX_PROG];
    int          prog_len  [NT];
    logic        cen_mode  [NT];  // 1 means random cen
    int          exp_n     [NT];
    logic [9:0]  exp_addr  [NT][MAX_WR];
    word_t       exp_data  [NT][MAX_WR];
    logic        pre_en    [NT];
    logic [9:0]  pre_addr  [NT];
    word_t       pre_data  [NT];

    // Write log filled by the RAM model
    logic [9:0]  wr_addr [MAX_WR*4];
    word_t       wr_data [MAX_WR*4];
    int          wr_count;

    logic        cen_rand;
    logic        cur_pre_en;
    logic [9:0]  cur_pre_addr;
    word_t       cur_pre_data;
    int          errors;
    int          passed;
    int          failed;

    dsp_core_top #(
        .RAM_AW (10)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .rom_addr  (rom_addr),
        .rom_dout  (rom_dout),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    always #4 clk = ~clk;

    assign rom_dout  = rom[rom_addr];
    assign ram_rdata = ram[ram_addr];

    // Cleared and preloaded in reset, written only on enabled edges
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 1024; i++) begin
                ram[i] <= (cur_pre_en && cur_pre_addr == 10'(i)) ? cur_pre_data : 16'h0000;
            end
            wr_count <= 0;
        end else if (cen && ram_we) begin
            ram[ram_addr] <= ram_wdata;
            if (wr_count < MAX_WR*4) begin
                wr_addr[wr_count] <= ram_addr;
                wr_data[wr_count] <= ram_wdata;
            end
            wr_count <= wr_count + 1;
        end
    end

    always @(posedge clk) begin
        cen <= cen_rand ? ($urandom_range(3) != 0) : 1'b1;  // About 3 of 4 edges enabled
    end

    // Instruction encoders
    function automatic word_t enc_short(logic [2:0] rg, logic [8:0] val);
        return {4'b0001, rg ^ 3'b100, val};
    endfunction

    function automatic word_t enc_long(logic [2:0] rg);
        return {5'b01010, 1'b0, 3'b000, rg, 4'b0000};
    endfunction

    function automatic word_t enc_store(logic [2:0] r, logic [1:0] y, logic [1:0] m);
        return {5'b01100, 4'b0000, r, y, m};
    endfunction

    function automatic word_t enc_load(logic [2:0] r, logic [1:0] y, logic [1:0] m);
        return {6'b011110, 3'b000, r, y, m};
    endfunction

    function automatic word_t enc_goto(logic [11:0] a);
        return {4'b0000, a};
    endfunction

    function automatic word_t enc_call(logic [11:0] a);
        return {4'b1000, a};
    endfunction

    task automatic add_write(int t, logic [9:0] a, word_t d);
        exp_addr[t][exp_n[t]] = a;
        exp_data[t][exp_n[t]] = d;
        exp_n[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < NT; t++) begin
            exp_n[t]    = 0;
            pre_en[t]   = 1'b0;
            pre_addr[t] = '0;
            pre_data[t] = '0;
            cen_mode[t] = 1'b0;
        end
        // Pointers store each other
        name[0] = "short loads and stores";
        prog[0][0] = enc_short(3'd0, 9'd10);
        prog[0][1] = enc_short(3'd1, 9'd20);
        prog[0][2] = enc_short(3'd2, 9'd30);
        prog[0][3] = enc_short(3'd3, 9'd40);
        prog[0][4] = enc_store(3'd0, 2'd1, 2'd0);
        prog[0][5] = enc_store(3'd1, 2'd2, 2'd0);
        prog[0][6] = enc_store(3'd2, 2'd3, 2'd0);
        prog[0][7] = enc_store(3'd3, 2'd0, 2'd0);
        prog_len[0] = 8;
        add_write(0, 10'd20, 16'd10);
        add_write(0, 10'd30, 16'd20);
        add_write(0, 10'd40, 16'd30);
        add_write(0, 10'd10, 16'd40);
        // Post-modify with wrap at 1024
        name[1] = "post-modify";
        prog[1][0] = enc_short(3'd4, 9'd5);
        prog[1][1] = enc_short(3'd0, 9'd7);
        prog[1][2] = enc_long(3'd1);
        prog[1][3] = 16'h03FE;
        prog[1][4] = enc_store(3'd0, 2'd1, 2'd1);
        prog[1][5] = enc_store(3'd0, 2'd1, 2'd1);
        prog[1][6] = enc_store(3'd0, 2'd1, 2'd2);
        prog[1][7] = enc_store(3'd0, 2'd1, 2'd3);
        prog[1][8] = enc_store(3'd0, 2'd1, 2'd0);
        prog_len[1] = 9;
        add_write(1, 10'd1022, 16'd7);
        add_write(1, 10'd1023, 16'd7);
        add_write(1, 10'd0, 16'd7);
        add_write(1, 10'd1023, 16'd7);
        add_write(1, 10'd4, 16'd7);
        // Value word would be a store if it ran
        name[2] = "long immediate";
        prog[2][0] = enc_long(3'd2);
        prog[2][1] = 16'h6457;
        prog[2][2] = enc_short(3'd0, 9'd3);
        prog[2][3] = enc_store(3'd2, 2'd0, 2'd0);
        prog_len[2] = 4;
        add_write(2, 10'd3, 16'h0057);
        // RAM load, then post-incremented r1
        name[3] = "RAM load";
        prog[3][0] = enc_short(3'd1, 9'd100);
        prog[3][1] = enc_short(3'd0, 9'd200);
        prog[3][2] = enc_short(3'd2, 9'd300);
        prog[3][3] = enc_load(3'd3, 2'd1, 2'd1);
        prog[3][4] = enc_store(3'd3, 2'd0, 2'd0);
        prog[3][5] = enc_store(3'd1, 2'd2, 2'd0);
        prog_len[3] = 6;
        pre_en[3]   = 1'b1;
        pre_addr[3] = 10'd100;
        pre_data[3] = 16'hF2A5;
        add_write(3, 10'd200, 16'h02A5);
        add_write(3, 10'd300, 16'd101);
        // goto skips 3 and 4, call runs 10, return lands on 6
        name[4] = "control flow";
        prog[4][0]  = enc_short(3'd0, 9'd11);
        prog[4][1]  = enc_short(3'd1, 9'd22);
        prog[4][2]  = enc_goto(12'd5);
        prog[4][3]  = enc_store(3'd0, 2'd0, 2'd0);
        prog[4][4]  = enc_store(3'd0, 2'd0, 2'd0);
        prog[4][5]  = enc_call(12'd10);
        prog[4][6]  = enc_store(3'd0, 2'd1, 2'd0);
        prog[4][7]  = enc_goto(12'd7);
        prog[4][8]  = enc_goto(12'd8);
        prog[4][9]  = enc_goto(12'd9);
        prog[4][10] = enc_store(3'd1, 2'd0, 2'd0);
        prog[4][11] = 16'hC000;  // goto B
        prog_len[4] = 12;
        add_write(4, 10'd11, 16'd22);
        add_write(4, 10'd22, 16'd11);
        // Same rows under random cen
        for (int k = 0; k < 2; k++) begin
            int src;
            src = (k == 0) ? 0 : 4;
            name[5+k]     = {name[src], ", random cen"};
            prog[5+k]     = prog[src];
            prog_len[5+k] = prog_len[src];
            exp_n[5+k]    = exp_n[src];
            exp_addr[5+k] = exp_addr[src];
            exp_data[5+k] = exp_data[src];
            cen_mode[5+k] = 1'b1;
        end
    endtask

    task automatic run_test(int t);
        int  cycles;
        int  test_err;
        logic timed_out;
        test_err  = 0;
        timed_out = 1'b0;
        @(posedge clk);
        rst          <= 1'b1;
        cen_rand     <= cen_mode[t];
        cur_pre_en   <= pre_en[t];
        cur_pre_addr <= pre_addr[t];
        cur_pre_data <= pre_data[t];
        for (int a = 0; a < 4096; a++) begin
            rom[a] = (a < prog_len[t]) ? prog[t][a] : enc_goto(12'(a));  // Self-jump fill
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < exp_n[t] && !timed_out; k++) begin
            cycles = 0;
            while (wr_count <= k && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (wr_count <= k) begin
                $display("Test %0d timed out waiting for RAM write %0d", t, k);
                timed_out = 1'b1;
                test_err++;
            end else begin
                assert (wr_addr[k] == exp_addr[t][k] && wr_data[k] == exp_data[t][k]) else begin
                    $display("ERROR at %0t: test %0d write %0d got %0d/%h, expected %0d/%h",
                             $time, t, k, wr_addr[k], wr_data[k],
                             exp_addr[t][k], exp_data[t][k]);
                    test_err++;
                end
            end
        end
        if (!timed_out) begin
            repeat (30) @(negedge clk);
            assert (wr_count == exp_n[t]) else begin
                $display("ERROR at %0t: test %0d saw %0d writes, expected %0d",
                         $time, t, wr_count, exp_n[t]);
                test_err++;
            end
        end

        errors += test_err;
        if (test_err == 0) begin
            passed++;
            $display("Test %0d (%s): pass", t, name[t]);
        end else begin
            failed++;
            $display("Test %0d (%s): FAIL with %0d errors", t, name[t], test_err);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        cen          = 1'b1;
        cen_rand     = 1'b0;
        cur_pre_en   = 1'b0;
        cur_pre_addr = '0;
        cur_pre_data = '0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        void'($urandom(61));
        build_table();

        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", NT, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/dsp_isa_pkg.sv
verilog/dsp_bus_pkg.sv
verilog/dsp_ctrl.sv
verilog/dsp_pc_unit.sv
verilog/dsp_ptr_unit.sv
verilog/dsp_mem_port.sv
verilog/dsp_core_top.sv
verification/dsp_core_checker.sv
verification/dsp_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dsp_core_tb -f project.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
else
    exit 1
fi
